/* tb.f */
src/pixel_cfg_pkg.sv
src/pixel_stream_pkg.sv
src/pixel_cfg_reg.sv
src/pixel_repacker.sv
src/pixel_stream_ctrl.sv
src/pixels_dw_top.sv
test/pixels_dw_tb.sv

/* test/pixels_dw_tb.sv */
`timescale 1ns/1ns

module pixels_dw_tb;

  localparam int IN_WORDS       = 4;
  localparam int UNITS          = 4;
  localparam int OUT_MAX        = UNITS + pixel_cfg_pkg::KH_MAX - 1;
  localparam int WW             = pixel_stream_pkg::WORD_WIDTH;
  localparam int SHIFT_W        = pixel_cfg_pkg::BITS_KH2 + 1;
  localparam int SEED           = 27;
  localparam int TIMEOUT_CYCLES = 4000; // Four images of ~30 beats each way under back-pressure x4

  // One output beat as seen on the output stream
  typedef struct packed {
    logic [OUT_MAX-1:0][WW-1:0] data;
    logic [SHIFT_W-1:0]         shift;
    logic                       ones;
    logic                       last;
    pixel_cfg_pkg::user_t       user;
  } beat_t;

  logic                         aclk;
  logic                         i_reset;
  logic                         i_s_valid;
  logic                         o_s_ready;
  logic                         i_s_last;
  logic [IN_WORDS-1:0][WW-1:0]  i_s_data;
  logic [IN_WORDS-1:0]          i_s_keep;
  logic                         o_m_valid;
  logic                         i_m_ready;
  logic [OUT_MAX-1:0][WW-1:0]   o_m_data;
  logic [SHIFT_W-1:0]           o_m_shift;
  logic                         o_m_ones;
  logic                         o_m_last;
  pixel_cfg_pkg::user_t         o_m_user;

  beat_t       exp_q[$];
  beat_t       act;
  beat_t       held_beat;
  logic        held = 1'b0;
  logic        in_frame = 1'b0;    // Next input beat belongs to a pixel payload
  logic        blocked = 1'b0;     // Between input last and output last
  logic        seen_config = 1'b0;
  logic [31:0] stim_state = SEED;
  logic [31:0] ready_state = ~SEED;
  int          cycles = 0;
  string       test_name = "reset";

  pixels_dw_top #(
    .IN_WORDS (IN_WORDS),
    .UNITS    (UNITS)
  ) dut (
    .aclk      (aclk),
    .i_reset   (i_reset),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_shift (o_m_shift),
    .o_m_ones  (o_m_ones),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

  initial aclk = 1'b0;
  always #10 aclk = ~aclk;

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned stim_rand(input int unsigned range);
    stim_state = lcg(stim_state);
    return stim_state[30:16] % range;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic value_error(input string check, input logic [127:0] exp,
                             input logic [127:0] actual);
    abort_run($sformatf("error %s %s: expected %0h, actual %0h",
                        test_name, check, exp, actual));
  endtask

  // Holds the beat on the input until o_s_ready is seen ahead of an edge
  task automatic send_beat(input logic [IN_WORDS-1:0][WW-1:0] data,
                           input logic [IN_WORDS-1:0] keep, input logic last);
    logic accepted;
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_keep  = keep;
    i_s_last  = last;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge aclk);
      accepted = o_s_ready;
      @(posedge aclk);
      #2;
    end
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
  endtask

  task automatic run_image(input int idx, input int words, input int kh2, input int sh_1);
    pixel_cfg_pkg::cfg_t         cfg;
    pixel_cfg_pkg::user_t        user;
    logic [2:0]                  flag_bits;
    logic [IN_WORDS*WW-1:0]      flat;
    logic [IN_WORDS-1:0][WW-1:0] img_data [16];
    logic [IN_WORDS-1:0]         last_keep;
    logic [WW-1:0]               pix_q[$];
    beat_t                       beat;
    int                          n_beats;
    int                          n_keep;
    int                          k;
    int                          s;
    int                          n_out;
    int                          gap;
    test_name = $sformatf("image%0d", idx);
    flag_bits = 3'(stim_rand(8));
    user      = flag_bits;
    cfg            = '0;
    cfg.words      = words;
    cfg.sh_1       = sh_1;
    cfg.kw2        = kh2;
    cfg.kh2        = kh2;
    cfg.is_lrelu   = user.is_lrelu;
    cfg.is_max     = user.is_max;
    cfg.is_not_max = user.is_not_max;
    flat = {16'(stim_rand(65536)), 16'(stim_rand(65536))}; // Upper bits are don't care
    flat[$bits(cfg)-1:0] = cfg;

    n_beats   = 10 + stim_rand(7);
    n_keep    = 1 + stim_rand(IN_WORDS);
    last_keep = IN_WORDS'((1 << n_keep) - 1);
    for (int b = 0; b < n_beats; b++) begin
      for (int j = 0; j < IN_WORDS; j++) begin
        img_data[b][j] = WW'(stim_rand(256));
        if (b < n_beats - 1 || j < n_keep) pix_q.push_back(img_data[b][j]);
      end
    end

    // Ones beat first, then the kept words cut into beats of the configured width
    beat         = '0;
    beat.data[0] = WW'(1);
    beat.ones    = 1'b1;
    beat.user    = user;
    exp_q.push_back(beat);
    k     = 2 * kh2 + 1;
    s     = sh_1 + 1;
    n_out = (pix_q.size() + words - 1) / words;
    for (int n = 0; n < n_out; n++) begin
      beat      = '0;
      beat.user = user;
      for (int j = 0; j < words; j++) begin
        if (n * words + j < pix_q.size()) beat.data[j] = pix_q[n * words + j];
      end
      beat.shift = (n % s == s - 1) ? SHIFT_W'(k / s - 1)
                                    : SHIFT_W'(k / s + ((k % s != 0) ? 1 : 0) - 1);
      beat.last  = (n == n_out - 1);
      exp_q.push_back(beat);
    end

    send_beat(flat, {IN_WORDS{1'b1}}, 1'b0);
    for (int b = 0; b < n_beats; b++) begin
      gap = stim_rand(3);
      repeat (gap) begin
        @(posedge aclk);
        #2;
      end
      send_beat(img_data[b], (b == n_beats - 1) ? last_keep : {IN_WORDS{1'b1}},
                b == n_beats - 1);
    end
  endtask

  task automatic check_output(input beat_t actual);
    beat_t exp;
    if (exp_q.size() == 0) begin
      abort_run($sformatf("%s: output beat arrived with no beat expected", test_name));
    end else begin
      exp = exp_q.pop_front();
      assert (actual.ones == exp.ones) else value_error("ones flag", exp.ones, actual.ones);
      assert (actual.shift == exp.shift) else value_error("shift", exp.shift, actual.shift);
      assert (actual.data == exp.data) else value_error("data", exp.data, actual.data);
      assert (actual.last == exp.last) else value_error("last", exp.last, actual.last);
      assert (actual.user == exp.user) else value_error("user flags", exp.user, actual.user);
    end
  endtask

  // Everything settles by the falling edge, so the monitor samples there
  always @(negedge aclk) begin
    if (!i_reset) begin
      act.data  = o_m_data;
      act.shift = o_m_shift;
      act.ones  = o_m_ones;
      act.last  = o_m_last;
      act.user  = o_m_user;
      if (held) begin
        assert (o_m_valid)
          else abort_run($sformatf("%s: o_m_valid dropped before the beat was taken",
                                   test_name));
        assert (act == held_beat) else value_error("held beat", held_beat, act);
      end
      assert (seen_config || !o_m_valid)
        else abort_run("o_m_valid went high before any config beat");
      assert (!blocked || !o_s_ready)
        else abort_run($sformatf("%s: o_s_ready high after the input last beat", test_name));
      assert (in_frame || blocked || o_s_ready)
        else abort_run($sformatf("%s: o_s_ready low while idle between images", test_name));
      if (o_m_valid && i_m_ready) check_output(act);
      held      = o_m_valid && !i_m_ready;
      held_beat = act;
      if (i_s_valid && o_s_ready) begin
        if (!in_frame) begin
          in_frame    = 1'b1;
          seen_config = 1'b1;
        end else if (i_s_last) begin
          in_frame = 1'b0;
          blocked  = 1'b1;
        end
      end
      if (o_m_valid && i_m_ready && o_m_last) blocked = 1'b0;
    end
  end

  // Random back-pressure on about one cycle in four
  always @(posedge aclk) begin
    #2;
    ready_state = lcg(ready_state);
    i_m_ready   = (ready_state[29:28] != 2'b00);
  end

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout after %0d cycles in %s, %0d beats still expected",
                          cycles, test_name, exp_q.size()));
    end
  end

  initial begin
    i_reset   = 1'b1;
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    i_s_data  = '0;
    i_s_keep  = '0;
    i_m_ready = 1'b0;
    repeat (8) @(posedge aclk);
    #2 i_reset = 1'b0;
    run_image(0, 4, 0, 0);
    run_image(1, 6, 1, 1);
    run_image(2, 8, 2, 2);
    run_image(3, 10, 3, 0);
    while (exp_q.size() != 0) @(posedge aclk);
    repeat (10) @(posedge aclk); // Any stray beat would show up here
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* src/pixels_dw_top.sv */
`timescale 1ns/1ns

module pixels_dw_top #(
  parameter int IN_WORDS = 4,
  parameter int UNITS    = 4,
  localparam int OUT_MAX = UNITS + pixel_cfg_pkg::KH_MAX - 1
) (
  input  logic                                                  aclk,
  input  logic                                                  i_reset,
  input  logic                                                  i_s_valid,
  output logic                                                  o_s_ready,
  input  logic                                                  i_s_last,
  input  logic [IN_WORDS-1:0][pixel_stream_pkg::WORD_WIDTH-1:0] i_s_data,
  input  logic [IN_WORDS-1:0]                                   i_s_keep,
  output logic                                                  o_m_valid,
  input  logic                                                  i_m_ready,
  output logic [OUT_MAX-1:0][pixel_stream_pkg::WORD_WIDTH-1:0]  o_m_data,
  output logic [pixel_cfg_pkg::BITS_KH2:0]                      o_m_shift,
  output logic                                                  o_m_ones,
  output logic                                                  o_m_last,
  output pixel_cfg_pkg::user_t                                  o_m_user
);

  localparam int CFG_W = $bits(pixel_cfg_pkg::cfg_t);

  logic [IN_WORDS*pixel_stream_pkg::WORD_WIDTH-1:0]            s_data_flat;
  pixel_cfg_pkg::cfg_t                                         config_word;
  pixel_cfg_pkg::cfg_t                                         cfg;
  logic [pixel_cfg_pkg::BITS_KH2:0]                            shift_general;
  logic [pixel_cfg_pkg::BITS_KH2:0]                            shift_last;
  logic                                                        config_en;
  logic                                                        rp_s_valid;
  logic                                                        rp_s_ready;
  logic                                                        rp_m_valid;
  logic                                                        rp_m_ready;
  logic                                                        rp_m_last;
  logic [OUT_MAX-1:0][pixel_stream_pkg::WORD_WIDTH-1:0]        rp_m_data;

  assign s_data_flat = i_s_data;
  assign config_word = pixel_cfg_pkg::cfg_t'(s_data_flat[CFG_W-1:0]); // Low bits of the first beat

  assign o_m_user = '{is_not_max: cfg.is_not_max, is_max: cfg.is_max, is_lrelu: cfg.is_lrelu};
  assign o_m_last = rp_m_last && !o_m_ones; // The ones beat never closes an image

  pixel_cfg_reg u_cfg_reg (
    .aclk            (aclk),
    .i_reset         (i_reset),
    .i_config_en     (config_en),
    .i_config_word   (config_word),
    .o_cfg           (cfg),
    .o_shift_general (shift_general),
    .o_shift_last    (shift_last)
  );

  pixel_repacker #(
    .IN_WORDS (IN_WORDS),
    .OUT_MAX  (OUT_MAX)
  ) u_repacker (
    .aclk      (aclk),
    .i_reset   (i_reset),
    .i_words   (cfg.words),
    .i_s_valid (rp_s_valid),
    .o_s_ready (rp_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .o_m_valid (rp_m_valid),
    .i_m_ready (rp_m_ready),
    .o_m_data  (rp_m_data),
    .o_m_last  (rp_m_last)
  );

  pixel_stream_ctrl #(
    .UNITS   (UNITS),
    .OUT_MAX (OUT_MAX)
  ) u_ctrl (
    .aclk            (aclk),
    .i_reset         (i_reset),
    .i_s_valid       (i_s_valid),
    .i_s_last        (i_s_last),
    .o_s_ready       (o_s_ready),
    .i_m_ready       (i_m_ready),
    .o_m_valid       (o_m_valid),
    .o_m_ones        (o_m_ones),
    .o_m_shift       (o_m_shift),
    .o_m_data        (o_m_data),
    .o_config_en     (config_en),
    .i_cfg           (cfg),
    .i_shift_general (shift_general),
    .i_shift_last    (shift_last),
    .o_rp_s_valid    (rp_s_valid),
    .i_rp_s_ready    (rp_s_ready),
    .o_rp_m_ready    (rp_m_ready),
    .i_rp_m_valid    (rp_m_valid),
    .i_rp_m_last     (rp_m_last),
    .i_rp_m_data     (rp_m_data)
  );

endmodule

/* src/pixel_stream_ctrl.sv */
`timescale 1ns/1ns

module pixel_stream_ctrl #(
  parameter int UNITS   = 4,
  parameter int OUT_MAX = 10
) (
  input  logic                                                 aclk,
  input  logic                                                 i_reset,
  input  logic                                                 i_s_valid,
  input  logic                                                 i_s_last,
  output logic                                                 o_s_ready,
  input  logic                                                 i_m_ready,
  output logic                                                 o_m_valid,
  output logic                                                 o_m_ones,
  output logic [pixel_cfg_pkg::BITS_KH2:0]                     o_m_shift,
  output logic [OUT_MAX-1:0][pixel_stream_pkg::WORD_WIDTH-1:0] o_m_data,
  output logic                                                 o_config_en,
  input  pixel_cfg_pkg::cfg_t                                  i_cfg,
  input  logic [pixel_cfg_pkg::BITS_KH2:0]                     i_shift_general,
  input  logic [pixel_cfg_pkg::BITS_KH2:0]                     i_shift_last,
  output logic                                                 o_rp_s_valid,
  input  logic                                                 i_rp_s_ready,
  output logic                                                 o_rp_m_ready,
  input  logic                                                 i_rp_m_valid,
  input  logic                                                 i_rp_m_last,
  input  logic [OUT_MAX-1:0][pixel_stream_pkg::WORD_WIDTH-1:0] i_rp_m_data
);

  localparam int SHIFT_W    = pixel_cfg_pkg::BITS_KH2 + 1;
  localparam int OVERLAP    = OUT_MAX - UNITS; // Words carried past the units in a full beat
  localparam int ONES_BEATS = 1;
  localparam int BITS_ONES  = $clog2(ONES_BEATS + 1);

  pixel_stream_pkg::ctrl_state_e state_q;
  pixel_stream_pkg::ctrl_state_e state_next;

  logic [BITS_ONES-1:0]              ones_count;
  logic [pixel_cfg_pkg::BITS_SH-1:0] count_sh;
  logic [SHIFT_W-1:0]                shift_sel;
  logic                              ones_last;
  logic                              count_sh_last;
  logic                              count_sh_en;
  logic                              s_beat;
  logic                              s_last_beat;
  logic                              m_beat;
  logic                              rp_last_beat;

  assign s_beat       = i_s_valid && o_s_ready;
  assign s_last_beat  = s_beat && i_s_last;
  assign m_beat       = o_m_valid && i_m_ready;
  assign rp_last_beat = o_rp_m_ready && i_rp_m_valid && i_rp_m_last;

  assign ones_last     = ones_count == BITS_ONES'(ONES_BEATS - 1);
  assign count_sh_last = count_sh == i_cfg.sh_1;
  assign shift_sel     = count_sh_last ? i_shift_last : i_shift_general;

  always_comb begin
    state_next = state_q;
    case (state_q)
      pixel_stream_pkg::ST_SET: begin
        if (s_beat) state_next = pixel_stream_pkg::ST_ONES;
      end
      pixel_stream_pkg::ST_ONES: begin
        if (ones_last && i_m_ready) state_next = pixel_stream_pkg::ST_PASS;
      end
      pixel_stream_pkg::ST_PASS: begin
        // Input last may already have gone in while the ones beat was out
        if (rp_last_beat) state_next = pixel_stream_pkg::ST_SET;
        else if (s_last_beat) state_next = pixel_stream_pkg::ST_BLOCK;
      end
      pixel_stream_pkg::ST_BLOCK: begin
        if (rp_last_beat) state_next = pixel_stream_pkg::ST_SET;
      end
      default: state_next = pixel_stream_pkg::ST_SET;
    endcase
  end

  always_comb begin
    o_config_en  = 1'b0;
    o_s_ready    = 1'b0;
    o_rp_s_valid = 1'b0;
    o_rp_m_ready = 1'b0;
    o_m_valid    = 1'b0;
    o_m_ones     = 1'b0;
    o_m_data     = i_rp_m_data;
    o_m_shift    = (shift_sel > OVERLAP) ? SHIFT_W'(OVERLAP) : shift_sel;
    count_sh_en  = 1'b0;
    case (state_q)
      pixel_stream_pkg::ST_SET: begin
        o_s_ready   = 1'b1;
        o_config_en = i_s_valid;
      end
      pixel_stream_pkg::ST_ONES: begin
        o_s_ready    = i_rp_s_ready; // Pixels may start filling the repacker
        o_rp_s_valid = i_s_valid;
        o_m_valid    = 1'b1;
        o_m_ones     = 1'b1;
        o_m_shift    = '0;
        o_m_data     = '0;
        o_m_data[0]  = pixel_stream_pkg::WORD_WIDTH'(1);
      end
      pixel_stream_pkg::ST_PASS: begin
        o_s_ready    = i_rp_s_ready;
        o_rp_s_valid = i_s_valid;
        o_rp_m_ready = i_m_ready;
        o_m_valid    = i_rp_m_valid;
        count_sh_en  = m_beat;
      end
      default: begin
        o_rp_m_ready = i_m_ready;
        o_m_valid    = i_rp_m_valid;
        count_sh_en  = m_beat;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      state_q    <= pixel_stream_pkg::ST_SET;
      ones_count <= '0;
      count_sh   <= '0;
    end else begin
      state_q <= state_next;
      if (state_q == pixel_stream_pkg::ST_SET) begin
        ones_count <= '0;
      end else if (state_q == pixel_stream_pkg::ST_ONES && m_beat) begin
        ones_count <= ones_count + 1'b1;
      end
      if (o_config_en) begin
        count_sh <= '0; // Every image starts on the first stride phase
      end else if (count_sh_en) begin
        count_sh <= count_sh_last ? '0 : count_sh + 1'b1;
      end
    end
  end

endmodule

/* src/pixel_repacker.sv */
`timescale 1ns/1ns

module pixel_repacker #(
  parameter int IN_WORDS = 4,
  parameter int OUT_MAX  = 10
) (
  input  logic                                                  aclk,
  input  logic                                                  i_reset,
  input  logic [pixel_cfg_pkg::BITS_WORDS-1:0]                  i_words,
  input  logic                                                  i_s_valid,
  output logic                                                  o_s_ready,
  input  logic                                                  i_s_last,
  input  logic [IN_WORDS-1:0][pixel_stream_pkg::WORD_WIDTH-1:0] i_s_data,
  input  logic [IN_WORDS-1:0]                                   i_s_keep,
  output logic                                                  o_m_valid,
  input  logic                                                  i_m_ready,
  output logic [OUT_MAX-1:0][pixel_stream_pkg::WORD_WIDTH-1:0]  o_m_data,
  output logic                                                  o_m_last
);

  localparam int WW    = pixel_stream_pkg::WORD_WIDTH;
  localparam int DEPTH = OUT_MAX + IN_WORDS - 1; // Room for one input beat on a near-full output
  localparam int CNT_W = $clog2(DEPTH + IN_WORDS + 1);

  logic [DEPTH-1:0][WW-1:0]   buf_q;
  logic [DEPTH-1:0][WW-1:0]   merged;
  logic [DEPTH-1:0][WW-1:0]   buf_next;
  logic [OUT_MAX-1:0][WW-1:0] out_data;
  logic [CNT_W-1:0]           fill_q;
  logic [CNT_W-1:0]           fill_mid;
  logic [CNT_W-1:0]           fill_next;
  logic [CNT_W-1:0]           words;
  logic [CNT_W-1:0]           kept;
  logic                       flush_q;
  logic                       flush_mid;
  logic                       flush_clear;
  logic                       s_beat;
  logic                       out_free;
  logic                       load;
  logic                       load_last;

  assign words     = CNT_W'(i_words);
  assign o_s_ready = !flush_q && (fill_q + IN_WORDS <= DEPTH);
  assign s_beat    = i_s_valid && o_s_ready;
  assign out_free  = !o_m_valid || i_m_ready;

  // Keep is contiguous from word 0, so its popcount is the append length
  always_comb begin
    kept = '0;
    for (int j = 0; j < IN_WORDS; j++) begin
      kept = kept + CNT_W'(i_s_keep[j]);
    end
  end

  // Incoming words land right behind the words already buffered
  always_comb begin
    merged   = buf_q;
    fill_mid = fill_q;
    if (s_beat) begin
      for (int j = 0; j < IN_WORDS; j++) begin
        if (i_s_keep[j]) begin
          merged[fill_q + j] = i_s_data[j];
        end
      end
      fill_mid = fill_q + kept;
    end
  end

  assign flush_mid   = flush_q || (s_beat && i_s_last);
  assign flush_clear = o_m_valid && o_m_last && i_m_ready;
  assign load_last   = flush_mid && (fill_mid <= words); // Remainder fits in one beat

  // Nothing more leaves once the last beat sits in the output register
  assign load = out_free && !(o_m_valid && o_m_last) &&
                (((fill_mid != '0) && (fill_mid >= words)) || flush_mid);

  always_comb begin
    for (int i = 0; i < OUT_MAX; i++) begin
      out_data[i] = (i < words && i < fill_mid) ? merged[i] : '0; // Zero pad past the fill
    end
  end

  always_comb begin
    buf_next  = merged;
    fill_next = fill_mid;
    if (load) begin
      for (int i = 0; i < DEPTH; i++) begin
        buf_next[i] = (i + words < DEPTH) ? merged[i + words] : '0;
      end
      fill_next = load_last ? '0 : fill_mid - words;
    end
  end

  always_ff @(posedge aclk) begin
    buf_q <= buf_next;
    if (load) begin
      o_m_data <= out_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      fill_q    <= '0;
      flush_q   <= 1'b0;
      o_m_valid <= 1'b0;
      o_m_last  <= 1'b0;
    end else begin
      fill_q  <= fill_next;
      flush_q <= flush_mid && !flush_clear;
      if (load) begin
        o_m_valid <= 1'b1;
        o_m_last  <= load_last;
      end else if (i_m_ready) begin
        o_m_valid <= 1'b0; // Beat taken, nothing new to show
      end
    end
  end

endmodule

/* src/pixel_cfg_reg.sv */
`timescale 1ns/1ns

module pixel_cfg_reg (
  input  logic                              aclk,
  input  logic                              i_reset,
  input  logic                              i_config_en,
  input  pixel_cfg_pkg::cfg_t               i_config_word,
  output pixel_cfg_pkg::cfg_t               o_cfg,
  output logic [pixel_cfg_pkg::BITS_KH2:0]  o_shift_general,
  output logic [pixel_cfg_pkg::BITS_KH2:0]  o_shift_last
);

  localparam int SHIFT_W = pixel_cfg_pkg::BITS_KH2 + 1;
  localparam int N_KH2   = 2 ** pixel_cfg_pkg::BITS_KH2;
  localparam int N_SH    = 2 ** pixel_cfg_pkg::BITS_SH;

  logic [N_KH2-1:0][N_SH-1:0][SHIFT_W-1:0] lut_general;
  logic [N_KH2-1:0][N_SH-1:0][SHIFT_W-1:0] lut_last;

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      o_cfg <= '0;
    end else if (i_config_en) begin
      o_cfg <= i_config_word;
    end
  end

  // Every kernel/stride pair gets its entry at elaboration time
  for (genvar i_kh2 = 0; i_kh2 < N_KH2; i_kh2++) begin : g_kh2
    for (genvar i_sh_1 = 0; i_sh_1 < N_SH; i_sh_1++) begin : g_sh
      localparam int K = 2 * i_kh2 + 1;
      localparam int S = (i_sh_1 < pixel_cfg_pkg::SH_MAX) ? i_sh_1 + 1 : pixel_cfg_pkg::SH_MAX;
      localparam int GENERAL = (K + S - 1) / S - 1; // ceil(k/s)-1
      localparam int LAST    = (K / S > 0) ? K / S - 1 : 0; // Stride wider than kernel gives 0

      assign lut_general[i_kh2][i_sh_1] = SHIFT_W'(GENERAL);
      assign lut_last[i_kh2][i_sh_1]    = SHIFT_W'(LAST);
    end
  end

  assign o_shift_general = lut_general[o_cfg.kh2][o_cfg.sh_1];
  assign o_shift_last    = lut_last[o_cfg.kh2][o_cfg.sh_1];

endmodule

/* src/pixel_stream_pkg.sv */
package pixel_stream_pkg;

  localparam int WORD_WIDTH = 8; // One pixel

  // Controller phases of one image packet
  typedef enum logic [1:0] {
    ST_SET   = 2'd0, // Waiting for the config beat
    ST_ONES  = 2'd1, // Presenting the ones beat
    ST_PASS  = 2'd2, // Repacked pixels flow out
    ST_BLOCK = 2'd3  // Input done, draining the repacker
  } ctrl_state_e;

endpackage

/* src/pixel_cfg_pkg.sv */
package pixel_cfg_pkg;

  // Kernel and stride limits of the accelerator
  localparam int KH_MAX    = 7;
  localparam int SH_MAX    = 3;
  localparam int WORDS_MAX = 16; // Widest output beat a config may ask for

  localparam int BITS_KH2   = $clog2(KH_MAX / 2 + 1);
  localparam int BITS_SH    = $clog2(SH_MAX);
  localparam int BITS_WORDS = $clog2(WORDS_MAX + 1);

  // Layout of the first beat of every packet, read from the low bits
  typedef struct packed {
    logic [BITS_WORDS-1:0] words;      // Units plus kernel overlap shift
    logic [BITS_SH-1:0]    sh_1;       // Stride minus one
    logic [BITS_KH2-1:0]   kw2;
    logic [BITS_KH2-1:0]   kh2;        // Half kernel height, k = 2*kh2+1
    logic                  is_lrelu;
    logic                  is_max;
    logic                  is_not_max;
  } cfg_t;

  // Flags that ride along with every output beat
  typedef struct packed {
    logic is_not_max;
    logic is_max;
    logic is_lrelu;
  } user_t;

endpackage
